// ==== common/dcache_geom_pkg.sv ====
package dcache_geom_pkg;

    // Byte address seen by the cache
    localparam int addr_w = 16;

    // 8 sets of 4 ways, 8-byte blocks
    localparam int set_count = 8;
    localparam int set_w = 3;
    localparam int way_count = 4;
    localparam int way_w = 2;

    // Address split is {tag, set, offset}
    localparam int offset_w = 3;
    localparam int tag_w = addr_w - set_w - offset_w;

    // One cache block, viewed at byte, half and word granularity
    typedef union packed {
        logic [7:0][7:0]  bytes;
        logic [3:0][15:0] halves;
        logic [1:0][31:0] words;
    } block_u;

endpackage

// ==== common/mem_access_pkg.sv ====
package mem_access_pkg;

    // Encoding is log2 of the byte count: 1, 2 or 4 bytes
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } access_size_e;

    // Miss handler states for the memory side
    localparam logic [1:0] miss_idle = 2'b00;
    localparam logic [1:0] miss_request = 2'b01;
    localparam logic [1:0] miss_wait_fill = 2'b10;
    localparam logic [1:0] miss_respond = 2'b11;

endpackage

// ==== dcache/dcache_data_array.sv ====
`timescale 1ns/1ns

module dcache_data_array (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic [dcache_geom_pkg::addr_w-1:0]    lookup_addr,
    output logic                                  hit,
    output logic [dcache_geom_pkg::way_w-1:0]     hit_way,
    output dcache_geom_pkg::block_u               hit_block,
    output logic                                  set_full,
    output logic [dcache_geom_pkg::way_w-1:0]     invalid_way,
    input  logic                                  fill_enable,
    input  logic [dcache_geom_pkg::addr_w-1:0]    fill_addr,
    input  logic [dcache_geom_pkg::way_w-1:0]     fill_way,
    input  dcache_geom_pkg::block_u               fill_block,
    input  logic                                  store_enable,
    input  mem_access_pkg::access_size_e          store_size,
    input  logic [31:0]                           store_data
);

    logic [dcache_geom_pkg::tag_w-1:0] tags [dcache_geom_pkg::set_count][dcache_geom_pkg::way_count];
    dcache_geom_pkg::block_u data [dcache_geom_pkg::set_count][dcache_geom_pkg::way_count];
    logic [dcache_geom_pkg::way_count-1:0] valid [dcache_geom_pkg::set_count];

    logic [dcache_geom_pkg::tag_w-1:0]    lookup_tag;
    logic [dcache_geom_pkg::set_w-1:0]    lookup_set;
    logic [dcache_geom_pkg::offset_w-1:0] lookup_offset;
    logic [dcache_geom_pkg::tag_w-1:0]    fill_tag;
    logic [dcache_geom_pkg::set_w-1:0]    fill_set;
    logic                                 fill_dup;

    // Address decode
    assign lookup_tag = lookup_addr[dcache_geom_pkg::addr_w-1 -: dcache_geom_pkg::tag_w];
    assign lookup_set = lookup_addr[dcache_geom_pkg::offset_w +: dcache_geom_pkg::set_w];
    assign lookup_offset = lookup_addr[dcache_geom_pkg::offset_w-1:0];
    assign fill_tag = fill_addr[dcache_geom_pkg::addr_w-1 -: dcache_geom_pkg::tag_w];
    assign fill_set = fill_addr[dcache_geom_pkg::offset_w +: dcache_geom_pkg::set_w];

    // Tag compare across the four ways
    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        for (int w = 0; w < dcache_geom_pkg::way_count; w++) begin
            if (valid[lookup_set][w] && tags[lookup_set][w] == lookup_tag) begin
                hit = 1'b1;
                hit_way = w[dcache_geom_pkg::way_w-1:0];
            end
        end
    end

    assign hit_block = data[lookup_set][hit_way];
    assign set_full = &valid[lookup_set];

    // Lowest invalid way wins, so scan from the top down
    always_comb begin
        invalid_way = '0;
        for (int w = dcache_geom_pkg::way_count - 1; w >= 0; w--) begin
            if (!valid[lookup_set][w]) begin
                invalid_way = w[dcache_geom_pkg::way_w-1:0];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < dcache_geom_pkg::set_count; s++) begin
                valid[s] <= '0;
            end
        end else if (fill_enable) begin
            valid[fill_set][fill_way] <= 1'b1;
        end
    end

    // Fill and store never coincide since stores are blocked during a miss
    always_ff @(posedge clock) begin
        if (fill_enable) begin
            data[fill_set][fill_way] <= fill_block;
            tags[fill_set][fill_way] <= fill_tag;
        end else if (store_enable) begin
            case (store_size)
                mem_access_pkg::size_byte:
                    data[lookup_set][hit_way].bytes[lookup_offset] <= store_data[7:0];
                mem_access_pkg::size_half:
                    data[lookup_set][hit_way].halves[lookup_offset[2:1]] <= store_data[15:0];
                default:
                    data[lookup_set][hit_way].words[lookup_offset[2]] <= store_data;
            endcase
        end
    end

    always_comb begin
        fill_dup = 1'b0;
        for (int w = 0; w < dcache_geom_pkg::way_count; w++) begin
            if (valid[fill_set][w] && tags[fill_set][w] == fill_tag) begin
                fill_dup = 1'b1;
            end
        end
    end

    // Miss control must only fill blocks that are absent from the set
    fill_no_duplicate: assert property (
        @(posedge clock) disable iff (reset) fill_enable |-> !fill_dup
    );

endmodule

// ==== dcache/dcache_miss_ctrl.sv ====
`timescale 1ns/1ns

module dcache_miss_ctrl (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                load_valid,
    input  logic                                load_miss,
    input  logic                                store_valid,
    input  logic [dcache_geom_pkg::addr_w-1:0]  load_addr,
    input  logic [dcache_geom_pkg::addr_w-1:0]  store_addr,
    input  mem_access_pkg::access_size_e        store_size,
    input  logic [31:0]                         store_data,
    input  logic                                mem_fill_valid,
    output logic                                busy,
    output logic                                mem_read,
    output logic                                mem_write,
    output logic [dcache_geom_pkg::addr_w-1:0]  mem_addr,
    output mem_access_pkg::access_size_e        mem_size,
    output logic [31:0]                         mem_wdata,
    output logic                                fill_enable,
    output logic [dcache_geom_pkg::addr_w-1:0]  miss_addr,
    output logic                                load_done
);

    logic [1:0]                         state;
    logic                               start_miss;
    logic [dcache_geom_pkg::addr_w-1:0] store_addr_r;
    mem_access_pkg::access_size_e       store_size_r;
    logic [31:0]                        store_data_r;

    assign start_miss = load_valid && load_miss;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= mem_access_pkg::miss_idle;
            load_done <= 1'b0;
            mem_write <= 1'b0;
        end else begin
            // Hit answers next cycle, a miss answers the cycle after the fill
            load_done <= (load_valid && !load_miss) || fill_enable;
            mem_write <= store_valid;
            case (state)
                mem_access_pkg::miss_request: state <= mem_access_pkg::miss_wait_fill;
                mem_access_pkg::miss_wait_fill: begin
                    if (mem_fill_valid) begin
                        state <= mem_access_pkg::miss_respond;
                    end
                end
                // Respond cycle is not busy and may take a new miss
                default: begin
                    state <= start_miss ? mem_access_pkg::miss_request : mem_access_pkg::miss_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (start_miss) begin
            miss_addr <= load_addr;
        end
        if (store_valid) begin
            store_addr_r <= store_addr;
            store_size_r <= store_size;
            store_data_r <= store_data;
        end
    end

    assign busy = (state == mem_access_pkg::miss_request) ||
                  (state == mem_access_pkg::miss_wait_fill);
    assign mem_read = (state == mem_access_pkg::miss_request);
    assign fill_enable = (state == mem_access_pkg::miss_wait_fill) && mem_fill_valid;

    // Block read and write-through pulse never overlap
    assign mem_addr = mem_read ?
        {miss_addr[dcache_geom_pkg::addr_w-1:dcache_geom_pkg::offset_w],
         {dcache_geom_pkg::offset_w{1'b0}}} : store_addr_r;
    assign mem_size = mem_read ? mem_access_pkg::size_word : store_size_r;
    assign mem_wdata = store_data_r;

    no_request_while_busy: assert property (
        @(posedge clock) disable iff (reset) busy |-> !(load_valid || store_valid)
    );

    no_fill_when_idle: assert property (
        @(posedge clock) disable iff (reset)
        (state == mem_access_pkg::miss_idle) |-> !mem_fill_valid
    );

endmodule

// ==== dcache/dcache_top.sv ====
`timescale 1ns/1ns

module dcache_top (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                load_valid,
    input  logic [dcache_geom_pkg::addr_w-1:0]  load_addr,
    input  mem_access_pkg::access_size_e        load_size,
    input  logic                                load_signed,
    input  logic                                store_valid,
    input  logic [dcache_geom_pkg::addr_w-1:0]  store_addr,
    input  mem_access_pkg::access_size_e        store_size,
    input  logic [31:0]                         store_data,
    input  logic                                mem_fill_valid,
    input  logic [63:0]                         mem_fill_data,
    output logic                                load_done,
    output logic [31:0]                         load_value,
    output logic                                busy,
    output logic                                mem_read,
    output logic                                mem_write,
    output logic [dcache_geom_pkg::addr_w-1:0]  mem_addr,
    output mem_access_pkg::access_size_e        mem_size,
    output logic [31:0]                         mem_wdata
);

    logic [dcache_geom_pkg::addr_w-1:0]   lookup_addr;
    logic [dcache_geom_pkg::addr_w-1:0]   miss_addr;
    logic                                 hit;
    logic                                 set_full;
    logic                                 fill_enable;
    logic                                 plru_update;
    logic [dcache_geom_pkg::way_w-1:0]    hit_way;
    logic [dcache_geom_pkg::way_w-1:0]    invalid_way;
    logic [dcache_geom_pkg::way_w-1:0]    victim_way;
    logic [dcache_geom_pkg::way_w-1:0]    fill_way;
    dcache_geom_pkg::block_u              hit_block;
    dcache_geom_pkg::block_u              fill_block;
    dcache_geom_pkg::block_u              load_block_r;
    logic [dcache_geom_pkg::offset_w-1:0] load_offset_r;
    mem_access_pkg::access_size_e         load_size_r;
    logic                                 load_signed_r;

    // During a miss the arrays look at the missing block for the fill
    assign lookup_addr = busy ? miss_addr : (store_valid ? store_addr : load_addr);
    assign fill_block = mem_fill_data;
    assign fill_way = set_full ? victim_way : invalid_way;
    assign plru_update = ((load_valid || store_valid) && hit) || fill_enable;

    // Load result staging, held across a miss until the fill arrives
    always_ff @(posedge clock) begin
        if (load_valid) begin
            load_offset_r <= load_addr[dcache_geom_pkg::offset_w-1:0];
            load_size_r <= load_size;
            load_signed_r <= load_signed;
        end
        if (fill_enable) begin
            load_block_r <= fill_block;
        end else if (load_valid) begin
            load_block_r <= hit_block;
        end
    end

    dcache_data_array data_array_i (
        .clock(clock), .reset(reset), .lookup_addr(lookup_addr),
        .hit(hit), .hit_way(hit_way), .hit_block(hit_block),
        .set_full(set_full), .invalid_way(invalid_way),
        .fill_enable(fill_enable), .fill_addr(miss_addr), .fill_way(fill_way),
        .fill_block(fill_block), .store_enable(store_valid && hit),
        .store_size(store_size), .store_data(store_data)
    );

    tree_plru plru_i (
        .clock(clock), .reset(reset),
        .lookup_set(lookup_addr[dcache_geom_pkg::offset_w +: dcache_geom_pkg::set_w]),
        .victim_way(victim_way), .update_enable(plru_update),
        .update_set(lookup_addr[dcache_geom_pkg::offset_w +: dcache_geom_pkg::set_w]),
        .update_way(fill_enable ? fill_way : hit_way)
    );

    dcache_miss_ctrl miss_ctrl_i (
        .clock(clock), .reset(reset), .load_valid(load_valid), .load_miss(!hit),
        .store_valid(store_valid), .load_addr(load_addr), .store_addr(store_addr),
        .store_size(store_size), .store_data(store_data),
        .mem_fill_valid(mem_fill_valid), .busy(busy), .mem_read(mem_read),
        .mem_write(mem_write), .mem_addr(mem_addr), .mem_size(mem_size),
        .mem_wdata(mem_wdata), .fill_enable(fill_enable), .miss_addr(miss_addr),
        .load_done(load_done)
    );

    load_align align_i (
        .block(load_block_r), .offset(load_offset_r), .size(load_size_r),
        .signed_load(load_signed_r), .value(load_value)
    );

endmodule

// ==== dcache/tree_plru.sv ====
`timescale 1ns/1ns

module tree_plru (
    input  logic                               clock,
    input  logic                               reset,
    input  logic [dcache_geom_pkg::set_w-1:0]  lookup_set,
    output logic [dcache_geom_pkg::way_w-1:0]  victim_way,
    input  logic                               update_enable,
    input  logic [dcache_geom_pkg::set_w-1:0]  update_set,
    input  logic [dcache_geom_pkg::way_w-1:0]  update_way
);

    // Per set {node2, node1, node0}
    //      node0
    //     /     \
    //  node1   node2
    //  /  \    /  \
    // w0  w1  w2  w3
    logic [2:0] status [dcache_geom_pkg::set_count];
    logic [2:0] lookup_bits;
    logic [2:0] update_bits;

    assign lookup_bits = status[lookup_set];
    assign update_bits = status[update_set];

    always_comb begin
        if (!lookup_bits[0]) begin
            victim_way = lookup_bits[1] ? 2'd1 : 2'd0;
        end else begin
            victim_way = lookup_bits[2] ? 2'd3 : 2'd2;
        end
    end

    // Point the tree away from the way just touched
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < dcache_geom_pkg::set_count; s++) begin
                status[s] <= 3'b000;
            end
        end else if (update_enable) begin
            case (update_way)
                2'd0: status[update_set] <= {update_bits[2], 1'b1, 1'b1};
                2'd1: status[update_set] <= {update_bits[2], 1'b0, 1'b1};
                2'd2: status[update_set] <= {1'b1, update_bits[1], 1'b0};
                default: status[update_set] <= {1'b0, update_bits[1], 1'b0};
            endcase
        end
    end

endmodule

// ==== dcache_top.f ====
+incdir+verif
common/dcache_geom_pkg.sv
common/mem_access_pkg.sv
rtl/load_align.sv
dcache/dcache_data_array.sv
dcache/tree_plru.sv
dcache/dcache_miss_ctrl.sv
dcache/dcache_top.sv
verif/dcache_tb.sv

// ==== rtl/load_align.sv ====
`timescale 1ns/1ns

module load_align (
    input  dcache_geom_pkg::block_u               block,
    input  logic [dcache_geom_pkg::offset_w-1:0]  offset,
    input  mem_access_pkg::access_size_e          size,
    input  logic                                  signed_load,
    output logic [31:0]                           value
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // Halves and words are assumed naturally aligned
    assign sel_byte = block.bytes[offset];
    assign sel_half = block.halves[offset[2:1]];

    always_comb begin
        case (size)
            mem_access_pkg::size_byte: begin
                value = {{24{signed_load & sel_byte[7]}}, sel_byte};
            end
            mem_access_pkg::size_half: begin
                value = {{16{signed_load & sel_half[15]}}, sel_half};
            end
            default: begin
                value = block.words[offset[2]];
            end
        endcase
    end

endmodule

// ==== verif/dcache_ref.svh ====
`ifndef DCACHE_REF_SVH
`define DCACHE_REF_SVH

// Shadow of the slow memory, one byte per address
logic [7:0] shadow [0:65535];
logic [15:0] lfsr_state = 16'd37076;

// Expected cache contents and tree bits {node2, node1, node0} per set
logic [9:0] model_tag [8][4];
logic [3:0] model_valid [8];
logic [2:0] model_plru [8];

// Taps 16, 14, 13, 11
function automatic logic random_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
endfunction

function automatic int random_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
        v = (v << 1) | random_bit();
    end
    return v;
endfunction

function automatic void shadow_fill();
    for (int a = 0; a < 65536; a++) begin
        shadow[a] = 8'(random_bits(8));
    end
endfunction

// Empty cache with all tree bits cleared, as after reset
function automatic void model_clear();
    for (int s = 0; s < 8; s++) begin
        model_valid[s] = '0;
        model_plru[s] = '0;
    end
endfunction

function automatic int byte_count(input mem_access_pkg::access_size_e size);
    if (size == mem_access_pkg::size_word) return 4;
    return (size == mem_access_pkg::size_half) ? 2 : 1;
endfunction

// Little-endian gather from the shadow, then extend
function automatic logic [31:0] expected_load(input logic [15:0] addr,
        input mem_access_pkg::access_size_e size, input logic sign_ext);
    int n;
    logic [31:0] value;
    n = byte_count(size);
    value = '0;
    for (int i = 0; i < 4; i++) begin
        if (i < n) begin
            value[8*i +: 8] = shadow[addr + i];
        end else if (sign_ext) begin
            value[8*i +: 8] = {8{value[8*n-1]}};
        end
    end
    return value;
endfunction

function automatic void plru_touch(input int s, input int w);
    if (w < 2) begin
        model_plru[s][0] = 1'b1;
        model_plru[s][1] = (w == 0);
    end else begin
        model_plru[s][0] = 1'b0;
        model_plru[s][2] = (w == 2);
    end
endfunction

function automatic int plru_victim(input int s);
    if (!model_plru[s][0]) return model_plru[s][1] ? 1 : 0;
    return model_plru[s][2] ? 3 : 2;
endfunction

// Predicts a hit and installs the block on a load miss
function automatic logic model_access(input logic [15:0] addr, input logic is_load);
    int s;
    int way;
    logic hit;
    s = addr[5:3];
    way = -1;
    for (int w = 3; w >= 0; w--) begin
        if (model_valid[s][w] && model_tag[s][w] == addr[15:6]) way = w;
    end
    hit = (way >= 0);
    if (!hit && !is_load) return 1'b0;
    if (!hit) begin
        way = plru_victim(s);
        for (int w = 3; w >= 0; w--) begin
            if (!model_valid[s][w]) way = w;
        end
        model_valid[s][way] = 1'b1;
        model_tag[s][way] = addr[15:6];
    end
    plru_touch(s, way);
    return hit;
endfunction

`endif

// ==== verif/dcache_tb.sv ====
`timescale 1ns/1ns

module dcache_tb;

    logic clock;
    logic reset;
    logic load_valid;
    logic [15:0] load_addr;
    mem_access_pkg::access_size_e load_size;
    logic load_signed;
    logic store_valid;
    logic [15:0] store_addr;
    mem_access_pkg::access_size_e store_size;
    logic [31:0] store_data;
    logic mem_fill_valid;
    logic [63:0] mem_fill_data;
    logic load_done;
    logic [31:0] load_value;
    logic busy;
    logic mem_read;
    logic mem_write;
    logic [15:0] mem_addr;
    mem_access_pkg::access_size_e mem_size;
    logic [31:0] mem_wdata;

    logic [31:0] expected_q [$];
    string test_name = "reset";
    int errors = 0;
    int test_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int read_count = 0;
    logic [15:0] last_read_addr;

    `include "dcache_ref.svh"

    dcache_top dut_i (.*);

    initial begin
        clock = 1'b0;
        forever begin
            #4 clock = ~clock;
        end
    end

    // Block reads answered after 1 to 6 cycles
    always @(negedge clock) begin
        if (mem_read) begin
            read_count++;
            last_read_addr = mem_addr;
            if (mem_size != mem_access_pkg::size_word) begin
                errors++;
                $display("CHECK FAILED %s mem_size expected %0d actual %0d", test_name,
                         mem_access_pkg::size_word, mem_size);
            end
            @(negedge clock);
            if (mem_read) begin
                errors++;
                $display("%s: mem_read held for more than one cycle", test_name);
            end
            repeat (random_bits(3) % 6) @(negedge clock);
            for (int i = 0; i < 8; i++) begin
                mem_fill_data[8*i +: 8] = shadow[last_read_addr + i];
            end
            mem_fill_valid = 1'b1;
            @(negedge clock);
            mem_fill_valid = 1'b0;
        end
    end

    // Write-through traffic lands in the shadow
    always @(negedge clock) begin
        if (mem_write) begin
            for (int i = 0; i < byte_count(mem_size); i++) begin
                shadow[mem_addr + i] = mem_wdata[8*i +: 8];
            end
        end
    end

    always @(negedge clock) begin
        if (load_done && expected_q.size() == 0) begin
            errors++;
            $display("%s: load_done pulsed with no load outstanding", test_name);
        end else if (load_done) begin
            if (load_value !== expected_q[0]) begin
                errors++;
                $display("CHECK FAILED %s load_value expected %h actual %h", test_name,
                         expected_q[0], load_value);
            end
            void'(expected_q.pop_front());
        end
    end

    task automatic finish_run();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors != test_errors) tests_failed++;
        $display("test %s: %s", test_name, (errors == test_errors) ? "ok" : "failed");
    endtask

    task automatic load_and_check(input logic [15:0] addr,
            input mem_access_pkg::access_size_e size, input logic sign_ext);
        int reads_before;
        int cycles;
        logic hit;
        reads_before = read_count;
        hit = model_access(addr, 1'b1);
        @(negedge clock);
        load_valid = 1'b1;
        load_addr = addr;
        load_size = size;
        load_signed = sign_ext;
        expected_q.push_back(expected_load(addr, size, sign_ext));
        @(negedge clock);
        load_valid = 1'b0;
        // A miss raises busy at the strobe edge, a hit leaves it low
        if (busy !== !hit) begin
            errors++;
            $display("CHECK FAILED %s busy expected %0b actual %0b", test_name, !hit, busy);
        end
        cycles = 0;
        while (!load_done && cycles < 40) begin
            @(negedge clock);
            cycles++;
        end
        if (!load_done) begin
            errors++;
            $display("%s: load from %h never completed", test_name, addr);
            finish_run();
        end else begin
            if (busy) begin
                errors++;
                $display("%s: busy still high when load at %h completed", test_name, addr);
            end
            if (hit && cycles != 0) begin
                errors++;
                $display("%s: hit at %h answered %0d cycles late", test_name, addr, cycles);
            end
            if (read_count != reads_before + (hit ? 0 : 1)) begin
                errors++;
                $display("CHECK FAILED %s mem_read count expected %0d actual %0d", test_name,
                         reads_before + (hit ? 0 : 1), read_count);
            end
            if (!hit && last_read_addr != {addr[15:3], 3'b000}) begin
                errors++;
                $display("CHECK FAILED %s mem_addr expected %h actual %h", test_name,
                         {addr[15:3], 3'b000}, last_read_addr);
            end
        end
    endtask

    // Back-to-back word loads within one cached block
    task automatic burst_hits(input logic [15:0] base, input int count);
        int reads_before;
        reads_before = read_count;
        for (int i = 0; i < count; i++) begin
            void'(model_access(16'(base + 4 * (i % 2)), 1'b1));
            @(negedge clock);
            if (i > 0 && !load_done) begin
                errors++;
                $display("%s: no load_done one cycle after strobe %0d", test_name, i - 1);
            end
            load_valid = 1'b1;
            load_addr = 16'(base + 4 * (i % 2));
            load_size = mem_access_pkg::size_word;
            load_signed = 1'b0;
            expected_q.push_back(expected_load(load_addr, load_size, 1'b0));
        end
        @(negedge clock);
        load_valid = 1'b0;
        if (!load_done) begin
            errors++;
            $display("%s: no load_done after the last strobe", test_name);
        end
        if (read_count != reads_before) begin
            errors++;
            $display("CHECK FAILED %s mem_read count expected %0d actual %0d", test_name,
                     reads_before, read_count);
        end
    endtask

    task automatic store_and_check(input logic [15:0] addr,
            input mem_access_pkg::access_size_e size, input logic [31:0] data);
        void'(model_access(addr, 1'b0));
        @(negedge clock);
        store_valid = 1'b1;
        store_addr = addr;
        store_size = size;
        store_data = data;
        @(negedge clock);
        store_valid = 1'b0;
        if (busy) begin
            errors++;
            $display("%s: busy went high after store to %h", test_name, addr);
        end
        if (!mem_write) begin
            errors++;
            $display("%s: no mem_write pulse after store to %h", test_name, addr);
        end else if (mem_addr != addr || mem_size != size || mem_wdata != data) begin
            errors++;
            $display("CHECK FAILED %s write expected %h actual %h", test_name,
                     {addr, size, data}, {mem_addr, mem_size, mem_wdata});
        end
    endtask

    initial begin
        logic [15:0] victim_addr;
        int touch_order [4];
        touch_order = '{3, 1, 4, 2};
        reset = 1'b1;
        load_valid = 1'b0;
        load_addr = '0;
        load_size = mem_access_pkg::size_byte;
        load_signed = 1'b0;
        store_valid = 1'b0;
        store_addr = '0;
        store_size = mem_access_pkg::size_byte;
        store_data = '0;
        mem_fill_valid = 1'b0;
        mem_fill_data = '0;
        shadow_fill();
        model_clear();
        repeat (2) @(negedge clock);
        reset = 1'b0;

        start_test("cold_miss");
        load_and_check(16'h0120, mem_access_pkg::size_word, 1'b0);
        finish_test();

        start_test("hit");
        load_and_check(16'h0124, mem_access_pkg::size_word, 1'b0);
        load_and_check(16'h0126, mem_access_pkg::size_half, 1'b1);
        burst_hits(16'h0120, 5);
        finish_test();

        start_test("extension");
        for (int sgn = 0; sgn < 2; sgn++) begin
            for (int off = 0; off < 8; off++) begin
                load_and_check(16'(16'h0120 + off), mem_access_pkg::size_byte, sgn[0]);
                load_and_check(16'(16'h0a58 + off), mem_access_pkg::size_byte, sgn[0]);
                if (off % 2 == 0) begin
                    load_and_check(16'(16'h0120 + off), mem_access_pkg::size_half, sgn[0]);
                    load_and_check(16'(16'h0a58 + off), mem_access_pkg::size_half, sgn[0]);
                end
            end
        end
        finish_test();

        start_test("store");
        store_and_check(16'h0122, mem_access_pkg::size_half, 32'h1234_b7c1);
        store_and_check(16'h0127, mem_access_pkg::size_byte, 32'h5566_779e);
        load_and_check(16'h0120, mem_access_pkg::size_word, 1'b0);
        load_and_check(16'h0124, mem_access_pkg::size_word, 1'b0);
        load_and_check(16'h0122, mem_access_pkg::size_half, 1'b1);
        // Store miss goes to memory only
        store_and_check(16'h3318, mem_access_pkg::size_word, 32'hc0de_1234);
        load_and_check(16'h3318, mem_access_pkg::size_word, 1'b0);
        finish_test();

        // Set 5 with tags 1 to 4, then a fifth tag
        start_test("replacement");
        for (int t = 1; t <= 4; t++) begin
            load_and_check(16'(64 * t + 40), mem_access_pkg::size_word, 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            load_and_check(16'(64 * touch_order[i] + 40), mem_access_pkg::size_word, 1'b0);
        end
        victim_addr = {model_tag[5][plru_victim(5)], 3'd5, 3'd0};
        load_and_check(16'(64 * 7 + 40), mem_access_pkg::size_word, 1'b0);
        for (int t = 1; t <= 4; t++) begin
            if (16'(64 * t + 40) != victim_addr) begin
                load_and_check(16'(64 * t + 40), mem_access_pkg::size_word, 1'b0);
            end
        end
        load_and_check(victim_addr, mem_access_pkg::size_word, 1'b0);
        finish_test();

        finish_run();
    end

endmodule
